/* verilog/cache_pkg.sv */
// Shared types and geometry for the data cache subsystem, referenced by scoped names
`default_nettype none

package cache_pkg;

  // Geometry
  localparam int NUM_WAYS = 2;
  localparam int NUM_SETS = 8;

  typedef logic [31:0] word_t;

  // Address split into tag, set index, word in block and byte in word
  typedef struct packed {
    logic [25:0] tag;
    logic [2:0]  idx;
    logic        blkoff;
    logic [1:0]  bytoff;
  } dcachef_t;

  // Same word seen whole for memory and split for lookup
  typedef union packed {
    word_t    raw;
    dcachef_t fields;
  } daddr_u;

  typedef struct packed {
    logic [25:0] tag;
    word_t [1:0] data;     // Word 0 at blkoff 0
    logic        valid;
    logic        dirty;
  } cache_frame_t;

  // Datapath side
  typedef struct packed {
    logic   ren;
    logic   wen;
    logic   halt;
    daddr_u addr;
    word_t  store;
  } dp_req_t;

  typedef struct packed {
    logic  hit;
    word_t load;
    logic  flushed;
  } dp_rsp_t;

  // Memory side
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } mem_req_t;

  typedef struct packed {
    logic  dwait;
    word_t load;
  } mem_rsp_t;

  // Array write port
  typedef struct packed {
    logic         en;
    logic         way;
    logic [2:0]   idx;
    cache_frame_t frame;
  } arr_wr_t;

  // Lookup result for the addressed set
  typedef struct packed {
    cache_frame_t [NUM_WAYS-1:0] frame;
    logic [NUM_WAYS-1:0]         hit;
    logic                        lru;   // Way to evict next
  } arr_rd_t;

endpackage

`default_nettype wire

/* verilog/dcache_array.sv */
// Two-way data cache storage with per-set LRU bits and tag compare, driven by dcache_ctrl
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
  input  logic                CLK,
  input  logic                nRST,
  input  logic [2:0]          rd_idx,
  input  cache_pkg::arr_wr_t  wr,
  input  logic                lru_upd_en,
  input  logic                lru_upd_way,
  input  logic [25:0]         lookup_tag,
  output cache_pkg::arr_rd_t  rd
);

  // Tag and data storage per way and set
  logic [25:0]              tag_mem  [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
  cache_pkg::word_t [1:0]   data_mem [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

  // Control bits per frame
  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] valid;
  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] dirty;

  logic [cache_pkg::NUM_SETS-1:0] lru;   // Set bit names the victim way

  // Frame payload write
  always_ff @(posedge CLK) begin
    if (wr.en) begin
      tag_mem[wr.way][wr.idx]  <= wr.frame.tag;
      data_mem[wr.way][wr.idx] <= wr.frame.data;
    end
  end

  // State bits and LRU
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;   // Way 0 goes first
    end else begin
      if (wr.en) begin
        valid[wr.way][wr.idx] <= wr.frame.valid;
        dirty[wr.way][wr.idx] <= wr.frame.dirty;
      end
      // A touched way makes the other one the victim
      if (lru_upd_en)
        lru[rd_idx] <= ~lru_upd_way;
    end
  end

  // Read both ways of the set and compare tags
  always_comb begin
    rd.lru = lru[rd_idx];
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      rd.frame[w].tag   = tag_mem[w][rd_idx];
      rd.frame[w].data  = data_mem[w][rd_idx];
      rd.frame[w].valid = valid[w][rd_idx];
      rd.frame[w].dirty = dirty[w][rd_idx];
      rd.hit[w]         = valid[w][rd_idx] && (tag_mem[w][rd_idx] == lookup_tag);
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
// Data cache controller for hits, write-back, block fill, halt flush and hit/miss counters
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  logic                CLK,
  input  logic                nRST,
  input  cache_pkg::dp_req_t  req,
  output cache_pkg::dp_rsp_t  rsp,
  input  cache_pkg::arr_rd_t  rd,
  output logic [2:0]          rd_idx,
  output logic [25:0]         lookup_tag,
  output cache_pkg::arr_wr_t  wr,
  output logic                lru_upd_en,
  output logic                lru_upd_way,
  output cache_pkg::mem_req_t mreq,
  input  cache_pkg::mem_rsp_t mrsp,
  output cache_pkg::word_t    hit_count,
  output cache_pkg::word_t    miss_count
);

  typedef enum logic [3:0] {
    IDLE,
    WB0,
    WB1,
    FILL0,
    FILL1,
    FLUSH_SCAN,
    FLUSH_WB0,
    FLUSH_WB1,
    FLUSHED
  } state_t;

  state_t                  state;
  state_t                  next_state;
  logic [3:0]              count;        // Flush position with the way in bit 3
  logic [3:0]              next_count;
  logic                    missed;       // Current request already missed
  logic                    access;
  logic                    idle_acc;
  logic                    hit_any;
  logic                    hit_way;
  logic                    hit_inc;
  logic                    miss_inc;
  logic                    flushing;
  logic                    sel_way;
  cache_pkg::cache_frame_t sel_frame;
  cache_pkg::cache_frame_t hit_frame;
  cache_pkg::word_t        fill_buf;     // First fill word
  cache_pkg::daddr_u       mem_addr;

  assign access     = req.ren | req.wen;
  assign idle_acc   = (state == IDLE) && access;
  assign hit_any    = |rd.hit;
  assign hit_way    = rd.hit[1];
  assign hit_inc    = idle_acc && hit_any && !missed;
  assign miss_inc   = idle_acc && !hit_any;
  assign flushing   = state inside {FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1};

  // Flush walks the array, otherwise the request picks the set
  assign rd_idx     = flushing ? count[2:0] : req.addr.fields.idx;
  assign lookup_tag = req.addr.fields.tag;
  assign sel_way    = flushing ? count[3] : rd.lru;
  assign sel_frame  = rd.frame[sel_way];
  assign hit_frame  = rd.frame[hit_way];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state      <= IDLE;
      count      <= '0;
      missed     <= 1'b0;
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      state <= next_state;
      count <= next_count;
      if (miss_inc)
        missed <= 1'b1;
      else if (idle_acc && hit_any)
        missed <= 1'b0;
      if (!req.halt) begin   // Counters frozen during halt
        if (hit_inc)
          hit_count <= hit_count + 32'd1;
        if (miss_inc)
          miss_count <= miss_count + 32'd1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (state == FILL0 && !mrsp.dwait)
      fill_buf <= mrsp.load;
  end

  always_comb begin
    next_state             = state;
    next_count             = count;
    rsp                    = '0;
    mreq                   = '0;
    mem_addr.raw           = req.addr.raw;
    mem_addr.fields.bytoff = 2'b00;
    wr.en                  = 1'b0;
    wr.way                 = sel_way;
    wr.idx                 = rd_idx;
    wr.frame               = sel_frame;
    lru_upd_en             = 1'b0;
    lru_upd_way            = hit_way;

    case (state)
      IDLE: begin
        if (access) begin
          if (hit_any) begin
            rsp.hit    = 1'b1;
            rsp.load   = hit_frame.data[req.addr.fields.blkoff];
            lru_upd_en = 1'b1;
            if (req.wen) begin
              wr.en                                 = 1'b1;
              wr.way                                = hit_way;
              wr.frame                              = hit_frame;
              wr.frame.data[req.addr.fields.blkoff] = req.store;
              wr.frame.dirty                        = 1'b1;
            end
          end else if (sel_frame.dirty) begin
            next_state = WB0;   // Victim must go back first
          end else begin
            next_state = FILL0;
          end
        end else if (req.halt) begin
          next_state = FLUSH_SCAN;
          next_count = '0;
        end
      end

      // Victim or flushed block goes back to memory word by word
      WB0, WB1, FLUSH_WB0, FLUSH_WB1: begin
        mem_addr.fields.tag    = sel_frame.tag;
        mem_addr.fields.idx    = rd_idx;
        mem_addr.fields.blkoff = (state == WB1) || (state == FLUSH_WB1);
        mreq.wen               = 1'b1;
        mreq.store             = sel_frame.data[mem_addr.fields.blkoff];
        if (!mrsp.dwait) begin
          case (state)
            WB0:       next_state = WB1;
            WB1:       next_state = FILL0;
            FLUSH_WB0: next_state = FLUSH_WB1;
            default: begin
              wr.en          = 1'b1;   // Block is clean in memory now
              wr.frame.dirty = 1'b0;
              next_count     = count + 4'd1;
              next_state     = (count == 4'd15) ? FLUSHED : FLUSH_SCAN;
            end
          endcase
        end
      end

      // Whole block read with the frame written on the second word
      FILL0, FILL1: begin
        mem_addr.fields.blkoff = (state == FILL1);
        mreq.ren               = 1'b1;
        if (!mrsp.dwait) begin
          if (state == FILL0) begin
            next_state = FILL1;
          end else begin
            wr.en            = 1'b1;
            wr.frame.tag     = req.addr.fields.tag;
            wr.frame.data[0] = fill_buf;
            wr.frame.data[1] = mrsp.load;
            wr.frame.valid   = 1'b1;
            wr.frame.dirty   = 1'b0;
            next_state       = IDLE;   // Request retries as a hit
          end
        end
      end

      FLUSH_SCAN: begin
        if (sel_frame.dirty)
          next_state = FLUSH_WB0;
        else if (count == 4'd15)
          next_state = FLUSHED;
        else
          next_count = count + 4'd1;
      end

      FLUSHED: rsp.flushed = 1'b1;   // Held until reset

      default: next_state = IDLE;
    endcase

    mreq.addr = mem_addr.raw;
  end

endmodule

`default_nettype wire

/* verilog/main_memory.sv */
// Word-wide main memory behind the cache, with a fixed number of wait states signalled on dwait
`timescale 1ns/1ps
`default_nettype none

module main_memory #(
  parameter int LATENCY   = 2,
  parameter int MEM_WORDS = 256
) (
  input  logic                CLK,
  input  logic                nRST,
  input  cache_pkg::mem_req_t mreq,
  output cache_pkg::mem_rsp_t mrsp
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int CW = (LATENCY > 0) ? $clog2(LATENCY + 1) : 1;

  cache_pkg::word_t ram [MEM_WORDS];
  logic [AW-1:0]    word_idx;
  logic [CW-1:0]    wait_cnt;
  logic             active;
  logic             done;

  // Word address wraps at the memory size
  assign word_idx = AW'(mreq.addr[31:2] % 32'(MEM_WORDS));

  assign active = mreq.ren | mreq.wen;
  assign done   = active && (wait_cnt == CW'(LATENCY));

  assign mrsp.dwait = active && !done;
  assign mrsp.load  = ram[word_idx];   // Valid once dwait drops

  // Wait states restart for every word
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      wait_cnt <= '0;
    else if (!active || done)
      wait_cnt <= '0;
    else
      wait_cnt <= wait_cnt + CW'(1);
  end

  // Each word starts out holding its own byte address
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int k = 0; k < MEM_WORDS; k++)
        ram[k] <= cache_pkg::word_t'(k * 4);
    end else if (mreq.wen && done) begin
      ram[word_idx] <= mreq.store;
    end
  end

endmodule

`default_nettype wire

/* verilog/cache_system.sv */
// Top level of the data cache subsystem joining controller, storage array and main memory
`timescale 1ns/1ps
`default_nettype none

module cache_system #(
  parameter int LATENCY   = 2,
  parameter int MEM_WORDS = 256
) (
  input  logic               CLK,
  input  logic               nRST,
  input  cache_pkg::dp_req_t req,
  output cache_pkg::dp_rsp_t rsp,
  output cache_pkg::word_t   hit_count,
  output cache_pkg::word_t   miss_count
);

  cache_pkg::arr_rd_t  rd;
  cache_pkg::arr_wr_t  wr;
  logic [2:0]          rd_idx;
  logic [25:0]         lookup_tag;
  logic                lru_upd_en;
  logic                lru_upd_way;
  cache_pkg::mem_req_t mreq;
  cache_pkg::mem_rsp_t mrsp;

  dcache_ctrl u_ctrl (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (req),
    .rsp         (rsp),
    .rd          (rd),
    .rd_idx      (rd_idx),
    .lookup_tag  (lookup_tag),
    .wr          (wr),
    .lru_upd_en  (lru_upd_en),
    .lru_upd_way (lru_upd_way),
    .mreq        (mreq),
    .mrsp        (mrsp),
    .hit_count   (hit_count),
    .miss_count  (miss_count)
  );

  dcache_array u_array (
    .CLK         (CLK),
    .nRST        (nRST),
    .rd_idx      (rd_idx),
    .wr          (wr),
    .lru_upd_en  (lru_upd_en),
    .lru_upd_way (lru_upd_way),
    .lookup_tag  (lookup_tag),
    .rd          (rd)
  );

  main_memory #(
    .LATENCY   (LATENCY),
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .CLK  (CLK),
    .nRST (nRST),
    .mreq (mreq),
    .mrsp (mrsp)
  );

endmodule

`default_nettype wire

/* tb/cache_system_chk.sv */
// Concurrent assertions on the cache controller's datapath and memory ports, bound into dcache_ctrl
`timescale 1ns/1ps
`default_nettype none

module cache_system_chk (
  input logic                CLK,
  input logic                nRST,
  input cache_pkg::dp_rsp_t  rsp,
  input cache_pkg::mem_req_t mreq,
  input cache_pkg::mem_rsp_t mrsp
);

  int unsigned fail_count = 0;   // Failed assertions so far

  // One memory operation at a time
  a_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(mreq.ren && mreq.wen))
    else begin
      $error("memory read and write requested together");
      fail_count++;
    end

  a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    rsp.flushed |=> rsp.flushed)
    else begin
      $error("flushed dropped before reset");
      fail_count++;
    end

  // Request held while memory is busy
  a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
    mrsp.dwait |=> $stable(mreq))
    else begin
      $error("memory request changed while dwait was high");
      fail_count++;
    end

  a_hit_no_mem: assert property (@(posedge CLK) disable iff (!nRST)
    rsp.hit |-> !(mreq.ren || mreq.wen))
    else begin
      $error("hit raised during a memory access");
      fail_count++;
    end

endmodule

bind dcache_ctrl cache_system_chk u_chk (
  .CLK  (CLK),
  .nRST (nRST),
  .rsp  (rsp),
  .mreq (mreq),
  .mrsp (mrsp)
);

`default_nettype wire

/* tb/tb_cache_system.sv */
// Testbench for cache_system with directed and random requests checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_cache_system;

  localparam int LATENCY      = 2;
  localparam int MEM_WORDS    = 256;
  localparam int NUM_RAND     = 100;
  localparam int WORD_CYC     = LATENCY + 1;                  // One memory word
  localparam int REQ_CYC      = 4 * WORD_CYC + 4;             // Dirty miss plus request gap
  localparam int FLUSH_CYC    = 16 + 16 * 2 * WORD_CYC + 2;   // Every block dirty
  localparam int WATCHDOG_CYC = 2 * (NUM_RAND + 25) * REQ_CYC;

  logic               CLK;
  logic               nRST;
  cache_pkg::dp_req_t req;
  cache_pkg::dp_rsp_t rsp;
  cache_pkg::word_t   hit_count;
  cache_pkg::word_t   miss_count;

  // Reference model with a flat memory as the datapath sees it and the tags of each way
  cache_pkg::word_t model_mem [MEM_WORDS];
  logic [25:0]      m_tag     [2][8];
  logic             m_valid   [2][8];
  logic             m_dirty   [2][8];
  logic             m_lru     [8];
  int unsigned      exp_hits;
  int unsigned      exp_misses;
  int               errors;
  integer           seed;

  cache_system #(
    .LATENCY   (LATENCY),
    .MEM_WORDS (MEM_WORDS)
  ) DUT (
    .CLK        (CLK),
    .nRST       (nRST),
    .req        (req),
    .rsp        (rsp),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYC);
    $display("sim failed");
    $finish;
  end

  // 256 words, so the word index is address bits 9 to 2
  function automatic logic [7:0] word_index(input cache_pkg::word_t addr);
    return addr[9:2];
  endfunction

  function automatic void init_model();
    for (int k = 0; k < MEM_WORDS; k++)
      model_mem[k[7:0]] = k * 4;
    for (int s = 0; s < 8; s++) begin
      m_lru[s[2:0]] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        m_tag[w[0]][s[2:0]]   = '0;
        m_valid[w[0]][s[2:0]] = 1'b0;
        m_dirty[w[0]][s[2:0]] = 1'b0;
      end
    end
    exp_hits   = 0;
    exp_misses = 0;
  endfunction

  // Updates the tag model and returns the cycles from request to hit
  function automatic int predict_access(input cache_pkg::word_t addr, input logic is_write);
    logic [25:0] tag;
    logic [2:0]  idx;
    logic        way;
    int          cycles;
    tag    = addr[31:6];
    idx    = addr[5:3];
    cycles = 1;
    if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
      way = 1'b0;
      exp_hits++;
    end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
      way = 1'b1;
      exp_hits++;
    end else begin
      way = m_lru[idx];
      exp_misses++;
      cycles = 2 + 2 * WORD_CYC;          // Miss cycle, two fills, retry
      if (m_valid[way][idx] && m_dirty[way][idx])
        cycles += 2 * WORD_CYC;           // Victim written back first
      m_tag[way][idx]   = tag;
      m_valid[way][idx] = 1'b1;
      m_dirty[way][idx] = 1'b0;
    end
    if (is_write)
      m_dirty[way][idx] = 1'b1;
    m_lru[idx] = ~way;
    return cycles;
  endfunction

  task automatic compare_word(input string what, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // One request held until hit, then latency, load and counters are checked
  task automatic do_access(input logic is_write, input cache_pkg::word_t addr,
                           input cache_pkg::word_t data, output int cyc);
    int               exp_cyc;
    cache_pkg::word_t exp_load;
    cache_pkg::word_t load;
    logic             seen;
    exp_load = model_mem[word_index(addr)];
    exp_cyc  = predict_access(addr, is_write);
    if (is_write)
      model_mem[word_index(addr)] = data;
    @(posedge CLK);
    req.ren      <= !is_write;
    req.wen      <= is_write;
    req.addr.raw <= addr;
    req.store    <= data;
    cyc  = 0;
    seen = 1'b0;
    load = '0;
    while (!seen && cyc < REQ_CYC) begin
      @(negedge CLK);
      cyc++;
      seen = rsp.hit;
      load = rsp.load;
    end
    @(posedge CLK);
    req.ren <= 1'b0;
    req.wen <= 1'b0;
    if (!seen) begin
      $display("Request to address %h never got a hit within %0d cycles", addr, REQ_CYC);
      errors++;
    end else if (cyc != exp_cyc) begin
      $display("[ERROR] %0t: access to %h took %0d cycles, expected %0d",
               $time, addr, cyc, exp_cyc);
      errors++;
    end
    if (seen && !is_write)
      compare_word("load data", load, exp_load);
    @(negedge CLK);   // Counters settle at the hit edge
    compare_word("hit_count", hit_count, cache_pkg::word_t'(exp_hits));
    compare_word("miss_count", miss_count, cache_pkg::word_t'(exp_misses));
  endtask

  task automatic reset_and_fill();
    int cyc;
    if (rsp.hit !== 1'b0 || rsp.flushed !== 1'b0) begin
      $display("[ERROR] %0t: hit or flushed high after reset", $time);
      errors++;
    end
    compare_word("hit_count after reset", hit_count, 32'd0);
    compare_word("miss_count after reset", miss_count, 32'd0);
    do_access(1'b0, 32'h0000_0040, '0, cyc);   // Cold miss
    compare_word("miss_count after first read", miss_count, 32'd1);
    compare_word("hit_count after first read", hit_count, 32'd0);
    do_access(1'b0, 32'h0000_0044, '0, cyc);   // Other word of the block
    compare_word("hit_count after second read", hit_count, 32'd1);
  endtask

  task automatic write_hit_readback();
    int cyc;
    do_access(1'b1, 32'h0000_0044, 32'hcafe_0044, cyc);
    do_access(1'b0, 32'h0000_0044, '0, cyc);
    do_access(1'b0, 32'h0000_0040, '0, cyc);   // Neighbour word untouched
  endtask

  // Three tags in set 2
  task automatic lru_eviction();
    int cyc;
    do_access(1'b1, 32'h0000_0090, 32'h1234_5678, cyc);   // Dirty in way 0
    do_access(1'b0, 32'h0000_00d0, '0, cyc);
    do_access(1'b0, 32'h0000_0090, '0, cyc);
    do_access(1'b0, 32'h0000_0110, '0, cyc);   // Must replace the second tag
    do_access(1'b0, 32'h0000_0090, '0, cyc);
    if (cyc != 1) begin
      $display("[ERROR] %0t: first tag was evicted instead of the LRU way", $time);
      errors++;
    end
    do_access(1'b0, 32'h0000_00d0, '0, cyc);
    do_access(1'b0, 32'h0000_0110, '0, cyc);   // Forces the dirty block out
    do_access(1'b0, 32'h0000_0090, '0, cyc);   // Back from memory
  endtask

  task automatic random_mix();
    cache_pkg::word_t r;
    cache_pkg::word_t addr;
    cache_pkg::word_t data;
    logic             is_write;
    int               cyc;
    for (int i = 0; i < NUM_RAND; i++) begin
      r        = $random(seed);
      addr     = {24'd0, r[5:0], 2'b00};   // 64 words with four tags per set
      is_write = r[7];
      data     = $random(seed);
      do_access(is_write, addr, data, cyc);
    end
    compare_word("final hit_count", hit_count, cache_pkg::word_t'(exp_hits));
    compare_word("final miss_count", miss_count, cache_pkg::word_t'(exp_misses));
  endtask

  task automatic halt_and_flush();
    cache_pkg::word_t hits0;
    cache_pkg::word_t misses0;
    cache_pkg::word_t load;
    logic             done;
    int               cyc;
    hits0   = hit_count;
    misses0 = miss_count;
    // A read still served under halt must leave the counters alone
    @(posedge CLK);
    req.halt     <= 1'b1;
    req.ren      <= 1'b1;
    req.addr.raw <= 32'h0000_0040;
    cyc  = 0;
    done = 1'b0;
    load = '0;
    while (!done && cyc < REQ_CYC) begin
      @(negedge CLK);
      cyc++;
      done = rsp.hit;
      load = rsp.load;
    end
    @(posedge CLK);
    req.ren <= 1'b0;
    if (!done) begin
      $display("Read under halt never got a hit within %0d cycles", REQ_CYC);
      errors++;
    end else begin
      compare_word("load under halt", load, model_mem[word_index(32'h0000_0040)]);
    end
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < FLUSH_CYC) begin
      @(negedge CLK);
      cyc++;
      done = rsp.flushed;
      compare_word("hit_count during flush", hit_count, hits0);
      compare_word("miss_count during flush", miss_count, misses0);
    end
    if (!done) begin
      $display("Flush did not finish within %0d cycles", FLUSH_CYC);
      errors++;
    end
    repeat (8) begin
      @(negedge CLK);
      if (rsp.flushed !== 1'b1 || rsp.hit !== 1'b0) begin
        $display("[ERROR] %0t: flushed dropped or hit rose after flush", $time);
        errors++;
      end
    end
    // Every dirty word has reached memory
    for (int k = 0; k < MEM_WORDS; k++)
      compare_word($sformatf("memory word %0d", k), DUT.u_mem.ram[k[7:0]], model_mem[k[7:0]]);
  endtask

  initial begin
    int asserts;
    seed   = 19110;
    errors = 0;
    nRST   = 1'b0;
    req    = '0;
    init_model();
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    reset_and_fill();
    write_hit_readback();
    lru_eviction();
    random_mix();
    halt_and_flush();
    asserts = int'(DUT.u_ctrl.u_chk.fail_count);
    $display("Summary: %0d check errors, %0d assertion failures", errors, asserts);
    if (errors == 0 && asserts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/cache_pkg.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/main_memory.sv
verilog/cache_system.sv
tb/cache_system_chk.sv
tb/tb_cache_system.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/1ps
TOP       := tb_cache_system
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
